/* rtl/decode_pkg.sv */
/*
 * Decode stage package
 * Shared widths, vector types, micro-op codes and RV32I opcode values
 * for the decode and operand-gather stage.
 */
package decode_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;   // PCs, register data, operands
    typedef logic [31:0]     instr_t;  // Encoded 32-bit instruction
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      alu_op_t;
    typedef logic [3:0]      lsu_op_t;
    typedef logic [3:0]      cfu_op_t;
    typedef logic [2:0]      imm_fmt_t;

    localparam reg_addr_t REG_ZERO = 5'd0;

    // ALU operations --------------------
    localparam alu_op_t ALU_OP_NOP  = 4'd0;
    localparam alu_op_t ALU_OP_ADD  = 4'd1;
    localparam alu_op_t ALU_OP_SUB  = 4'd2;
    localparam alu_op_t ALU_OP_AND  = 4'd3;
    localparam alu_op_t ALU_OP_OR   = 4'd4;
    localparam alu_op_t ALU_OP_XOR  = 4'd5;
    localparam alu_op_t ALU_OP_SLL  = 4'd6;
    localparam alu_op_t ALU_OP_SRL  = 4'd7;
    localparam alu_op_t ALU_OP_SRA  = 4'd8;
    localparam alu_op_t ALU_OP_SLT  = 4'd9;
    localparam alu_op_t ALU_OP_SLTU = 4'd10;

    // Load/store operations --------------------
    localparam lsu_op_t LSU_OP_NONE = 4'd0;
    localparam lsu_op_t LSU_OP_LB   = 4'd1;
    localparam lsu_op_t LSU_OP_LBU  = 4'd2;
    localparam lsu_op_t LSU_OP_LH   = 4'd3;
    localparam lsu_op_t LSU_OP_LHU  = 4'd4;
    localparam lsu_op_t LSU_OP_LW   = 4'd5;
    localparam lsu_op_t LSU_OP_SB   = 4'd6;
    localparam lsu_op_t LSU_OP_SH   = 4'd7;
    localparam lsu_op_t LSU_OP_SW   = 4'd8;

    // Control flow operations --------------------
    localparam cfu_op_t CFU_OP_NONE   = 4'd0;
    localparam cfu_op_t CFU_OP_BEQ    = 4'd1;
    localparam cfu_op_t CFU_OP_BNE    = 4'd2;
    localparam cfu_op_t CFU_OP_BLT    = 4'd3;
    localparam cfu_op_t CFU_OP_BGE    = 4'd4;
    localparam cfu_op_t CFU_OP_BLTU   = 4'd5;
    localparam cfu_op_t CFU_OP_BGEU   = 4'd6;
    localparam cfu_op_t CFU_OP_JAL    = 4'd7;  // Also used for JALR
    localparam cfu_op_t CFU_OP_ECALL  = 4'd8;
    localparam cfu_op_t CFU_OP_EBREAK = 4'd9;

    // Immediate formats
    localparam imm_fmt_t IMM_NONE  = 3'd0;
    localparam imm_fmt_t IMM_I     = 3'd1;
    localparam imm_fmt_t IMM_S     = 3'd2;
    localparam imm_fmt_t IMM_B     = 3'd3;
    localparam imm_fmt_t IMM_U     = 3'd4;
    localparam imm_fmt_t IMM_J     = 3'd5;
    localparam imm_fmt_t IMM_SHAMT = 3'd6;  // 5-bit shift amount, zero-extended

    // Major opcodes --------------------
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    // Full encodings of the two SYSTEM instructions kept
    localparam instr_t INSTR_ECALL  = 32'h0000_0073;
    localparam instr_t INSTR_EBREAK = 32'h0010_0073;

endpackage

/* rtl/uop_if.sv */
/*
 * Micro-op bus
 * One decoded micro-op with its operand selects, from the decoder
 * to the immediate generator, operand mux and stage register.
 */
interface uop_if;
    import decode_pkg::*;

    alu_op_t   alu_op;
    lsu_op_t   lsu_op;
    cfu_op_t   cfu_op;
    reg_addr_t rd;
    imm_fmt_t  imm_fmt;
    logic      sel_a_rs1, sel_a_pc;               // Operand A sources
    logic      sel_b_rs2, sel_b_imm;              // Operand B sources
    logic      sel_c_rs2, sel_c_imm, sel_c_npc;   // Operand C sources

    modport dec (output alu_op, lsu_op, cfu_op, rd, imm_fmt,
                 output sel_a_rs1, sel_a_pc, sel_b_rs2, sel_b_imm,
                 output sel_c_rs2, sel_c_imm, sel_c_npc);

    // Consumer side
    modport user (input alu_op, lsu_op, cfu_op, rd, imm_fmt,
                  input sel_a_rs1, sel_a_pc, sel_b_rs2, sel_b_imm,
                  input sel_c_rs2, sel_c_imm, sel_c_npc);

endinterface

/* rtl/uop_decode.sv */
/*
 * Instruction decoder
 * Recognizes RV32I instructions and produces micro-op codes, operand
 * selects, the immediate format and the register addresses.
 */
module uop_decode (
    input  decode_pkg::instr_t    instr_i,
    uop_if.dec                    uop_o,
    output decode_pkg::reg_addr_t rs1_addr_o,
    output decode_pkg::reg_addr_t rs2_addr_o
);
    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       use_rd;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // Standard funct3 map, alt picks SUB / SRA
    function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'd0:    return alt ? ALU_OP_SUB : ALU_OP_ADD;
            3'd1:    return ALU_OP_SLL;
            3'd2:    return ALU_OP_SLT;
            3'd3:    return ALU_OP_SLTU;
            3'd4:    return ALU_OP_XOR;
            3'd5:    return alt ? ALU_OP_SRA : ALU_OP_SRL;
            3'd6:    return ALU_OP_OR;
            default: return ALU_OP_AND;
        endcase
    endfunction

    always_comb begin
        uop_o.alu_op    = ALU_OP_NOP;
        uop_o.lsu_op    = LSU_OP_NONE;
        uop_o.cfu_op    = CFU_OP_NONE;
        uop_o.imm_fmt   = IMM_NONE;
        uop_o.sel_a_rs1 = 1'b0;
        uop_o.sel_a_pc  = 1'b0;
        uop_o.sel_b_rs2 = 1'b0;
        uop_o.sel_b_imm = 1'b0;
        uop_o.sel_c_rs2 = 1'b0;
        uop_o.sel_c_imm = 1'b0;
        uop_o.sel_c_npc = 1'b0;
        use_rd          = 1'b0;
        case (opcode)
            OPC_LUI: begin
                uop_o.alu_op = ALU_OP_OR;  // 0 | imm
                {uop_o.sel_b_imm, use_rd} = 2'b11;
                uop_o.imm_fmt = IMM_U;
            end
            OPC_AUIPC: begin
                uop_o.alu_op = ALU_OP_ADD;
                {uop_o.sel_a_pc, uop_o.sel_b_imm, use_rd} = 3'b111;
                uop_o.imm_fmt = IMM_U;
            end
            OPC_JAL: begin
                uop_o.cfu_op = CFU_OP_JAL;
                {uop_o.sel_a_pc, uop_o.sel_b_imm, uop_o.sel_c_npc, use_rd} = 4'b1111;
                uop_o.imm_fmt = IMM_J;
            end
            OPC_JALR: if (funct3 == 3'd0) begin
                uop_o.cfu_op = CFU_OP_JAL;
                {uop_o.sel_a_rs1, uop_o.sel_b_imm, uop_o.sel_c_npc, use_rd} = 4'b1111;
                uop_o.imm_fmt = IMM_I;
            end
            OPC_BRANCH: if (funct3[2:1] != 2'b01) begin  // f3 = 2,3 are reserved
                uop_o.alu_op = ALU_OP_SUB;
                uop_o.cfu_op = (funct3 == 3'd0) ? CFU_OP_BEQ  :
                               (funct3 == 3'd1) ? CFU_OP_BNE  :
                               (funct3 == 3'd4) ? CFU_OP_BLT  :
                               (funct3 == 3'd5) ? CFU_OP_BGE  :
                               (funct3 == 3'd6) ? CFU_OP_BLTU : CFU_OP_BGEU;
                {uop_o.sel_a_rs1, uop_o.sel_b_rs2, uop_o.sel_c_imm} = 3'b111;
                uop_o.imm_fmt = IMM_B;
            end
            OPC_LOAD: if (funct3 != 3'd3 && funct3 < 3'd6) begin
                uop_o.alu_op = ALU_OP_ADD;
                uop_o.lsu_op = (funct3 == 3'd0) ? LSU_OP_LB  :
                               (funct3 == 3'd1) ? LSU_OP_LH  :
                               (funct3 == 3'd2) ? LSU_OP_LW  :
                               (funct3 == 3'd4) ? LSU_OP_LBU : LSU_OP_LHU;
                {uop_o.sel_a_rs1, uop_o.sel_b_imm, use_rd} = 3'b111;
                uop_o.imm_fmt = IMM_I;
            end
            OPC_STORE: if (funct3 < 3'd3) begin
                uop_o.alu_op = ALU_OP_ADD;
                uop_o.lsu_op = (funct3 == 3'd0) ? LSU_OP_SB :
                               (funct3 == 3'd1) ? LSU_OP_SH : LSU_OP_SW;
                {uop_o.sel_a_rs1, uop_o.sel_b_imm, uop_o.sel_c_rs2} = 3'b111;
                uop_o.imm_fmt = IMM_S;
            end
            OPC_OP_IMM: begin
                // Shifts need a clean funct7, SRAI may set bit 30
                if (funct3 == 3'd1 && funct7 == 7'h00 ||
                    funct3 == 3'd5 && (funct7 == 7'h00 || funct7 == 7'h20)) begin
                    uop_o.alu_op  = alu_from_f3(funct3, instr_i[30]);
                    uop_o.imm_fmt = IMM_SHAMT;
                    {uop_o.sel_a_rs1, uop_o.sel_b_imm, use_rd} = 3'b111;
                end else if (funct3 != 3'd1 && funct3 != 3'd5) begin
                    uop_o.alu_op  = alu_from_f3(funct3, 1'b0);
                    uop_o.imm_fmt = IMM_I;
                    {uop_o.sel_a_rs1, uop_o.sel_b_imm, use_rd} = 3'b111;
                end
            end
            OPC_OP: if (funct7 == 7'h00 ||
                        funct7 == 7'h20 && (funct3 == 3'd0 || funct3 == 3'd5)) begin
                uop_o.alu_op = alu_from_f3(funct3, instr_i[30]);
                {uop_o.sel_a_rs1, uop_o.sel_b_rs2, use_rd} = 3'b111;
            end
            OPC_MISC_MEM: ;  // FENCE retires as a no-op
            OPC_SYSTEM: begin
                if (instr_i == INSTR_ECALL)  uop_o.cfu_op = CFU_OP_ECALL;
                if (instr_i == INSTR_EBREAK) uop_o.cfu_op = CFU_OP_EBREAK;
            end
            default: ;
        endcase
    end

    // Register addresses --------------------
    assign rs1_addr_o = uop_o.sel_a_rs1 ? instr_i[19:15] : REG_ZERO;
    assign rs2_addr_o = (uop_o.sel_b_rs2 || uop_o.sel_c_rs2) ? instr_i[24:20] : REG_ZERO;
    assign uop_o.rd   = use_rd ? instr_i[11:7] : REG_ZERO;

    // The AND-OR operand mux downstream relies on one-hot selects
    always_comb begin
        assert #0 ($onehot0({uop_o.sel_a_rs1, uop_o.sel_a_pc}) &&
                   $onehot0({uop_o.sel_c_rs2, uop_o.sel_c_imm, uop_o.sel_c_npc}))
            else $error("uop_decode: more than one operand A or C select");
    end

endmodule

/* rtl/imm_gen.sv */
/*
 * Immediate generator
 * Builds the sign-extended immediate of the decoded format for operand B,
 * plus the branch offset for operand C.
 */
module imm_gen (
    input  decode_pkg::instr_t instr_i,
    uop_if.user                uop_i,
    output decode_pkg::xlen_t  imm_o,
    output decode_pkg::xlen_t  imm_b_o
);
    import decode_pkg::*;

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_u;
    xlen_t imm_j;
    xlen_t imm_shamt;

    assign imm_i     = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s     = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u     = {instr_i[31:12], 12'b0};
    assign imm_j     = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};
    assign imm_shamt = {27'b0, instr_i[24:20]};

    // Branch offset, always formed for operand C
    assign imm_b_o   = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};

    always_comb begin
        case (uop_i.imm_fmt)
            IMM_I:     imm_o = imm_i;
            IMM_S:     imm_o = imm_s;
            IMM_U:     imm_o = imm_u;
            IMM_J:     imm_o = imm_j;
            IMM_SHAMT: imm_o = imm_shamt;
            default:   imm_o = '0;  // IMM_B only reaches operand C
        endcase
    end

endmodule

/* rtl/operand_select.sv */
/*
 * Operand select
 * AND-OR muxes forming execute operands A, B and C. No select set
 * gives zero.
 */
module operand_select (
    uop_if.user               uop_i,
    input  decode_pkg::xlen_t rs1_data_i,
    input  decode_pkg::xlen_t rs2_data_i,
    input  decode_pkg::xlen_t pc_i,
    input  decode_pkg::xlen_t npc_i,
    input  decode_pkg::xlen_t imm_i,
    input  decode_pkg::xlen_t imm_b_i,
    output decode_pkg::xlen_t opr_a_o,
    output decode_pkg::xlen_t opr_b_o,
    output decode_pkg::xlen_t opr_c_o
);
    import decode_pkg::*;

    assign opr_a_o = {XLEN{uop_i.sel_a_rs1}} & rs1_data_i |
                     {XLEN{uop_i.sel_a_pc }} & pc_i;

    assign opr_b_o = {XLEN{uop_i.sel_b_rs2}} & rs2_data_i |
                     {XLEN{uop_i.sel_b_imm}} & imm_i;

    assign opr_c_o = {XLEN{uop_i.sel_c_rs2}} & rs2_data_i |   // Store data
                     {XLEN{uop_i.sel_c_imm}} & imm_b_i    |   // Branch offset
                     {XLEN{uop_i.sel_c_npc}} & npc_i;         // Link address

    // An immediate on B with no format would silently read zero
    always_comb begin
        assert #0 (!uop_i.sel_b_imm || uop_i.imm_fmt != IMM_NONE)
            else $error("operand_select: immediate selected without a format");
    end

endmodule

/* rtl/decode_stage_reg.sv */
/*
 * Decode to execute register
 * Captures the decoded micro-op and operands on valid and ready, with
 * synchronous flush and asynchronous reset.
 */
module decode_stage_reg (
    input  logic                  g_clk,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  logic                  ready_i,
    input  logic                  flush_i,
    uop_if.user                   uop_i,
    input  decode_pkg::xlen_t     pc_i,
    input  decode_pkg::xlen_t     opr_a_i,
    input  decode_pkg::xlen_t     opr_b_i,
    input  decode_pkg::xlen_t     opr_c_i,
    output decode_pkg::xlen_t     pc_o,
    output decode_pkg::xlen_t     opr_a_o,
    output decode_pkg::xlen_t     opr_b_o,
    output decode_pkg::xlen_t     opr_c_o,
    output decode_pkg::reg_addr_t rd_o,
    output decode_pkg::alu_op_t   alu_op_o,
    output decode_pkg::lsu_op_t   lsu_op_o,
    output decode_pkg::cfu_op_t   cfu_op_o
);
    import decode_pkg::*;

    logic capture;

    assign capture = valid_i && ready_i;

    always_ff @(posedge g_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o     <= '0;
            opr_a_o  <= '0;
            opr_b_o  <= '0;
            opr_c_o  <= '0;
            rd_o     <= REG_ZERO;
            alu_op_o <= ALU_OP_NOP;
            lsu_op_o <= LSU_OP_NONE;
            cfu_op_o <= CFU_OP_NONE;
        end else if (flush_i) begin  // Flush wins over capture
            pc_o     <= '0;
            opr_a_o  <= '0;
            opr_b_o  <= '0;
            opr_c_o  <= '0;
            rd_o     <= REG_ZERO;
            alu_op_o <= ALU_OP_NOP;
            lsu_op_o <= LSU_OP_NONE;
            cfu_op_o <= CFU_OP_NONE;
        end else if (capture) begin
            pc_o     <= pc_i;
            opr_a_o  <= opr_a_i;
            opr_b_o  <= opr_b_i;
            opr_c_o  <= opr_c_i;
            rd_o     <= uop_i.rd;
            alu_op_o <= uop_i.alu_op;
            lsu_op_o <= uop_i.lsu_op;
            cfu_op_o <= uop_i.cfu_op;
        end
    end

    // Execute must never see a live op the cycle after a flush
    a_flush_kills_ops: assert property (@(posedge g_clk) disable iff (!rst_n_i)
        flush_i |=> (alu_op_o == ALU_OP_NOP && lsu_op_o == LSU_OP_NONE &&
                     cfu_op_o == CFU_OP_NONE))
        else $error("decode_stage_reg: op code live after flush");

endmodule

/* rtl/decode_stage.sv */
/*
 * Decode and operand-gather stage
 * RV32I decode, register read addressing, operand selection and
 * the register into execute.
 */
module decode_stage (
    input  logic                  g_clk,
    input  logic                  rst_n_i,
    // Fetch side
    input  logic                  s1_valid_i,
    input  decode_pkg::instr_t    s1_instr_i,
    input  decode_pkg::xlen_t     s1_pc_i,
    input  decode_pkg::xlen_t     s1_npc_i,
    input  logic                  s1_flush_i,
    output logic                  s1_eat_o,
    // Register file, forwarded read data
    output decode_pkg::reg_addr_t s1_rs1_addr_o,
    input  decode_pkg::xlen_t     s1_rs1_data_i,
    output decode_pkg::reg_addr_t s1_rs2_addr_o,
    input  decode_pkg::xlen_t     s1_rs2_data_i,
    // Execute side
    output logic                  s2_valid_o,
    input  logic                  s2_ready_i,
    output decode_pkg::xlen_t     s2_pc_o,
    output decode_pkg::xlen_t     s2_opr_a_o,
    output decode_pkg::xlen_t     s2_opr_b_o,
    output decode_pkg::xlen_t     s2_opr_c_o,
    output decode_pkg::reg_addr_t s2_rd_o,
    output decode_pkg::alu_op_t   s2_alu_op_o,
    output decode_pkg::lsu_op_t   s2_lsu_op_o,
    output decode_pkg::cfu_op_t   s2_cfu_op_o
);
    import decode_pkg::*;

    xlen_t imm;        // Operand B immediate
    xlen_t imm_b;      // Branch offset
    xlen_t n_opr_a;
    xlen_t n_opr_b;
    xlen_t n_opr_c;

    uop_if uop_bus ();

    // Stage handshake --------------------
    assign s1_eat_o   = s1_valid_i && s2_ready_i;
    assign s2_valid_o = s1_valid_i;

    uop_decode i_uop_decode (
        .instr_i    (s1_instr_i),
        .uop_o      (uop_bus),
        .rs1_addr_o (s1_rs1_addr_o),
        .rs2_addr_o (s1_rs2_addr_o)
    );

    imm_gen i_imm_gen (
        .instr_i (s1_instr_i),
        .uop_i   (uop_bus),
        .imm_o   (imm),
        .imm_b_o (imm_b)
    );

    operand_select i_operand_select (
        .uop_i      (uop_bus),
        .rs1_data_i (s1_rs1_data_i),
        .rs2_data_i (s1_rs2_data_i),
        .pc_i       (s1_pc_i),
        .npc_i      (s1_npc_i),
        .imm_i      (imm),
        .imm_b_i    (imm_b),
        .opr_a_o    (n_opr_a),
        .opr_b_o    (n_opr_b),
        .opr_c_o    (n_opr_c)
    );

    decode_stage_reg i_decode_stage_reg (
        .g_clk    (g_clk),
        .rst_n_i  (rst_n_i),
        .valid_i  (s1_valid_i),
        .ready_i  (s2_ready_i),
        .flush_i  (s1_flush_i),
        .uop_i    (uop_bus),
        .pc_i     (s1_pc_i),
        .opr_a_i  (n_opr_a),
        .opr_b_i  (n_opr_b),
        .opr_c_i  (n_opr_c),
        .pc_o     (s2_pc_o),
        .opr_a_o  (s2_opr_a_o),
        .opr_b_o  (s2_opr_b_o),
        .opr_c_o  (s2_opr_c_o),
        .rd_o     (s2_rd_o),
        .alu_op_o (s2_alu_op_o),
        .lsu_op_o (s2_lsu_op_o),
        .cfu_op_o (s2_cfu_op_o)
    );

endmodule

/* tb/tb_decode_stage.sv */
/*
 * Decode stage testbench
 * Table-driven checks of decode, operand selection, ready hold,
 * flush and reset on the decode_stage top level.
 */
module tb_decode_stage;
    import decode_pkg::*;

    // Operand source tags
    localparam int SRC_ZERO = 0;
    localparam int SRC_RS1  = 1;
    localparam int SRC_RS2  = 2;
    localparam int SRC_PC   = 3;
    localparam int SRC_NPC  = 4;
    localparam int SRC_IMM  = 5;
    localparam int MAX_TESTS = 32;

    logic      g_clk;
    logic      rst_n_i;
    logic      s1_valid_i, s1_flush_i, s2_ready_i;
    instr_t    s1_instr_i;
    xlen_t     s1_pc_i, s1_npc_i, s1_rs1_data_i, s1_rs2_data_i;
    logic      s1_eat_o, s2_valid_o;
    reg_addr_t s1_rs1_addr_o, s1_rs2_addr_o, s2_rd_o;
    xlen_t     s2_pc_o, s2_opr_a_o, s2_opr_b_o, s2_opr_c_o;
    alu_op_t   s2_alu_op_o;
    lsu_op_t   s2_lsu_op_o;
    cfu_op_t   s2_cfu_op_o;

    // Stimulus table
    string     t_name[$];
    instr_t    t_instr[$];
    reg_addr_t t_rs1[$], t_rs2[$], t_rd[$];
    alu_op_t   t_alu[$];
    lsu_op_t   t_lsu[$];
    cfu_op_t   t_cfu[$];
    int        t_a_src[$], t_b_src[$], t_c_src[$];
    xlen_t     t_imm[$];

    // Data sources drawn per entry
    xlen_t rs1_val [0:MAX_TESTS-1];
    xlen_t rs2_val [0:MAX_TESTS-1];
    xlen_t pc_val  [0:MAX_TESTS-1];
    xlen_t npc_val [0:MAX_TESTS-1];

    logic [15:0] lfsr = 16'd19009;
    int          checks = 0;
    int          mismatches = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    decode_stage i_decode_stage (.*);

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    // Timeout --------------------
    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic xlen_t rand_word();
        xlen_t w;
        logic  fb;
        w = '0;
        for (int k = 0; k < XLEN; k++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            w    = {w[XLEN-2:0], fb};
        end
        return w;
    endfunction

    // Instruction encoders --------------------
    function automatic instr_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_test(string name, instr_t instr, reg_addr_t rs1, reg_addr_t rs2,
                            reg_addr_t rd, alu_op_t alu, lsu_op_t lsu, cfu_op_t cfu,
                            int a_src, int b_src, int c_src, xlen_t imm);
        t_name.push_back(name);
        t_instr.push_back(instr);
        t_rs1.push_back(rs1);
        t_rs2.push_back(rs2);
        t_rd.push_back(rd);
        t_alu.push_back(alu);
        t_lsu.push_back(lsu);
        t_cfu.push_back(cfu);
        t_a_src.push_back(a_src);
        t_b_src.push_back(b_src);
        t_c_src.push_back(c_src);
        t_imm.push_back(imm);
    endtask

    task automatic build_table();
        add_test("add", enc_r(7'h00, 2, 1, 3'd0, 3, OPC_OP), 1, 2, 3,
                 ALU_OP_ADD, LSU_OP_NONE, CFU_OP_NONE, SRC_RS1, SRC_RS2, SRC_ZERO, 0);
        add_test("sub", enc_r(7'h20, 7, 6, 3'd0, 5, OPC_OP), 6, 7, 5,
                 ALU_OP_SUB, LSU_OP_NONE, CFU_OP_NONE, SRC_RS1, SRC_RS2, SRC_ZERO, 0);
        add_test("sra", enc_r(7'h20, 10, 9, 3'd5, 8, OPC_OP), 9, 10, 8,
                 ALU_OP_SRA, LSU_OP_NONE, CFU_OP_NONE, SRC_RS1, SRC_RS2, SRC_ZERO, 0);
        add_test("sltu", enc_r(7'h00, 13, 12, 3'd3, 11, OPC_OP), 12, 13, 11,
                 ALU_OP_SLTU, LSU_OP_NONE, CFU_OP_NONE, SRC_RS1, SRC_RS2, SRC_ZERO, 0);
        add_test("xor", enc_r(7'h00, 16, 15, 3'd4, 14, OPC_OP), 15, 16, 14,
                 ALU_OP_XOR, LSU_OP_NONE, CFU_OP_NONE, SRC_RS1, SRC_RS2, SRC_ZERO, 0);
        add_test("mul", enc_r(7'h01, 2, 1, 3'd0, 3, OPC_OP), 0, 0, 0,  // M extension absent
                 ALU_OP_NOP, LSU_OP_NONE, CFU_OP_NONE, SRC_ZERO, SRC_ZERO, SRC_ZERO, 0);
        add_test("addi", enc_i(12'hFFB, 2, 3'd0, 1, OPC_OP_IMM), 2, 0, 1,
                 ALU_OP_ADD, LSU_OP_NONE, CFU_OP_NONE, SRC_RS1, SRC_IMM, SRC_ZERO, 32'hFFFF_FFFB);
        add_test("andi", enc_i(12'h7F0, 5, 3'd7, 4, OPC_OP_IMM), 5, 0, 4,
                 ALU_OP_AND, LSU_OP_NONE, CFU_OP_NONE, SRC_RS1, SRC_IMM, SRC_ZERO, 32'h7F0);
        add_test("slli", enc_i({7'h00, 5'd13}, 7, 3'd1, 6, OPC_OP_IMM), 7, 0, 6,
                 ALU_OP_SLL, LSU_OP_NONE, CFU_OP_NONE, SRC_RS1, SRC_IMM, SRC_ZERO, 13);
        add_test("srai", enc_i({7'h20, 5'd31}, 9, 3'd5, 8, OPC_OP_IMM), 9, 0, 8,
                 ALU_OP_SRA, LSU_OP_NONE, CFU_OP_NONE, SRC_RS1, SRC_IMM, SRC_ZERO, 31);
        add_test("slti", enc_i(12'hFFF, 11, 3'd2, 10, OPC_OP_IMM), 11, 0, 10,
                 ALU_OP_SLT, LSU_OP_NONE, CFU_OP_NONE, SRC_RS1, SRC_IMM, SRC_ZERO, 32'hFFFF_FFFF);
        add_test("lw", enc_i(12'hFFC, 13, 3'd2, 12, OPC_LOAD), 13, 0, 12,
                 ALU_OP_ADD, LSU_OP_LW, CFU_OP_NONE, SRC_RS1, SRC_IMM, SRC_ZERO, 32'hFFFF_FFFC);
        add_test("lbu", enc_i(12'h123, 15, 3'd4, 14, OPC_LOAD), 15, 0, 14,
                 ALU_OP_ADD, LSU_OP_LBU, CFU_OP_NONE, SRC_RS1, SRC_IMM, SRC_ZERO, 32'h123);
        add_test("lh", enc_i(12'h7FF, 2, 3'd1, 1, OPC_LOAD), 2, 0, 1,
                 ALU_OP_ADD, LSU_OP_LH, CFU_OP_NONE, SRC_RS1, SRC_IMM, SRC_ZERO, 32'h7FF);
        add_test("sw", enc_s(12'h010, 16, 17, 3'd2), 17, 16, 0,
                 ALU_OP_ADD, LSU_OP_SW, CFU_OP_NONE, SRC_RS1, SRC_IMM, SRC_RS2, 32'h10);
        add_test("sb", enc_s(12'hFE0, 18, 19, 3'd0), 19, 18, 0,
                 ALU_OP_ADD, LSU_OP_SB, CFU_OP_NONE, SRC_RS1, SRC_IMM, SRC_RS2, 32'hFFFF_FFE0);
        add_test("beq", enc_b(13'h0008, 21, 20, 3'd0), 20, 21, 0,
                 ALU_OP_SUB, LSU_OP_NONE, CFU_OP_BEQ, SRC_RS1, SRC_RS2, SRC_IMM, 32'h8);
        add_test("bne", enc_b(13'h1FF0, 23, 22, 3'd1), 22, 23, 0,
                 ALU_OP_SUB, LSU_OP_NONE, CFU_OP_BNE, SRC_RS1, SRC_RS2, SRC_IMM, 32'hFFFF_FFF0);
        add_test("bltu", enc_b(13'h0800, 25, 24, 3'd6), 24, 25, 0,
                 ALU_OP_SUB, LSU_OP_NONE, CFU_OP_BLTU, SRC_RS1, SRC_RS2, SRC_IMM, 32'h800);
        add_test("bgeu", enc_b(13'h1000, 27, 26, 3'd7), 26, 27, 0,
                 ALU_OP_SUB, LSU_OP_NONE, CFU_OP_BGEU, SRC_RS1, SRC_RS2, SRC_IMM, 32'hFFFF_F000);
        add_test("jal", enc_j(21'h18_1234, 1), 0, 0, 1,
                 ALU_OP_NOP, LSU_OP_NONE, CFU_OP_JAL, SRC_PC, SRC_IMM, SRC_NPC, 32'hFFF8_1234);
        add_test("jalr", enc_i(12'h044, 6, 3'd0, 5, OPC_JALR), 6, 0, 5,
                 ALU_OP_NOP, LSU_OP_NONE, CFU_OP_JAL, SRC_RS1, SRC_IMM, SRC_NPC, 32'h44);
        add_test("lui", {20'hABCDE, 5'd7, OPC_LUI}, 0, 0, 7,
                 ALU_OP_OR, LSU_OP_NONE, CFU_OP_NONE, SRC_ZERO, SRC_IMM, SRC_ZERO, 32'hABCD_E000);
        add_test("auipc", {20'h80001, 5'd8, OPC_AUIPC}, 0, 0, 8,
                 ALU_OP_ADD, LSU_OP_NONE, CFU_OP_NONE, SRC_PC, SRC_IMM, SRC_ZERO, 32'h8000_1000);
        add_test("fence", 32'h0FF0_000F, 0, 0, 0,
                 ALU_OP_NOP, LSU_OP_NONE, CFU_OP_NONE, SRC_ZERO, SRC_ZERO, SRC_ZERO, 0);
        add_test("ecall", 32'h0000_0073, 0, 0, 0,
                 ALU_OP_NOP, LSU_OP_NONE, CFU_OP_ECALL, SRC_ZERO, SRC_ZERO, SRC_ZERO, 0);
        add_test("ebreak", 32'h0010_0073, 0, 0, 0,
                 ALU_OP_NOP, LSU_OP_NONE, CFU_OP_EBREAK, SRC_ZERO, SRC_ZERO, SRC_ZERO, 0);
        add_test("illegal", 32'hFFFF_FFFF, 0, 0, 0,
                 ALU_OP_NOP, LSU_OP_NONE, CFU_OP_NONE, SRC_ZERO, SRC_ZERO, SRC_ZERO, 0);
    endtask

    function automatic xlen_t exp_operand(int src, int i);
        case (src)
            SRC_RS1: return rs1_val[i];
            SRC_RS2: return rs2_val[i];
            SRC_PC:  return pc_val[i];
            SRC_NPC: return npc_val[i];
            SRC_IMM: return t_imm[i];
            default: return '0;
        endcase
    endfunction

    task automatic compare(string test, string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s %s: expected 0x%08h, actual 0x%08h", test, what, exp, act);
        end
    endtask

    // Fresh data sources each time an entry is presented
    task automatic drive_entry(int i, logic rdy);
        rs1_val[i] = rand_word();
        rs2_val[i] = rand_word();
        pc_val[i]  = rand_word();
        npc_val[i] = rand_word();
        s1_valid_i    <= 1'b1;
        s1_instr_i    <= t_instr[i];
        s1_pc_i       <= pc_val[i];
        s1_npc_i      <= npc_val[i];
        s1_rs1_data_i <= rs1_val[i];
        s1_rs2_data_i <= rs2_val[i];
        s2_ready_i    <= rdy;
    endtask

    task automatic check_comb(int i, logic exp_eat);
        compare(t_name[i], "rs1_addr", t_rs1[i], s1_rs1_addr_o);
        compare(t_name[i], "rs2_addr", t_rs2[i], s1_rs2_addr_o);
        compare(t_name[i], "eat", exp_eat, s1_eat_o);
        compare(t_name[i], "s2_valid", 1, s2_valid_o);
    endtask

    // No instruction present while execute is still ready
    task automatic check_idle(string test);
        compare(test, "eat", 0, s1_eat_o);
        compare(test, "s2_valid", 0, s2_valid_o);
    endtask

    task automatic check_stage(int i);
        compare(t_name[i], "pc", pc_val[i], s2_pc_o);
        compare(t_name[i], "opr_a", exp_operand(t_a_src[i], i), s2_opr_a_o);
        compare(t_name[i], "opr_b", exp_operand(t_b_src[i], i), s2_opr_b_o);
        compare(t_name[i], "opr_c", exp_operand(t_c_src[i], i), s2_opr_c_o);
        compare(t_name[i], "rd", t_rd[i], s2_rd_o);
        compare(t_name[i], "alu_op", t_alu[i], s2_alu_op_o);
        compare(t_name[i], "lsu_op", t_lsu[i], s2_lsu_op_o);
        compare(t_name[i], "cfu_op", t_cfu[i], s2_cfu_op_o);
    endtask

    task automatic check_zero(string test);
        compare(test, "pc", 0, s2_pc_o);
        compare(test, "opr_a", 0, s2_opr_a_o);
        compare(test, "opr_b", 0, s2_opr_b_o);
        compare(test, "opr_c", 0, s2_opr_c_o);
        compare(test, "rd", 0, s2_rd_o);
        compare(test, "alu_op", 0, s2_alu_op_o);
        compare(test, "lsu_op", 0, s2_lsu_op_o);
        compare(test, "cfu_op", 0, s2_cfu_op_o);
    endtask

    initial begin
        int n;
        rst_n_i       = 1'b0;
        s1_valid_i    = 1'b0;
        s1_instr_i    = '0;
        s1_pc_i       = '0;
        s1_npc_i      = '0;
        s1_flush_i    = 1'b0;
        s1_rs1_data_i = '0;
        s1_rs2_data_i = '0;
        s2_ready_i    = 1'b0;
        build_table();
        n = t_name.size();
        cycle_limit = n * 4 + 40;
        repeat (2) @(posedge g_clk);
        rst_n_i <= 1'b1;
        @(negedge g_clk);
        check_zero("after_reset");

        // Back to back captures, result checked one cycle later
        for (int i = 0; i <= n; i++) begin
            @(posedge g_clk);
            if (i < n)
                drive_entry(i, 1'b1);
            else
                s1_valid_i <= 1'b0;
            @(negedge g_clk);
            if (i < n)
                check_comb(i, 1'b1);
            else
                check_idle("idle");
            if (i > 0)
                check_stage(i - 1);
        end

        // Ready low --------------------
        @(posedge g_clk);
        drive_entry(0, 1'b0);
        @(negedge g_clk);
        check_comb(0, 1'b0);
        check_stage(n - 1);
        @(posedge g_clk);
        @(negedge g_clk);
        check_stage(n - 1);      // Still holding
        @(posedge g_clk);
        s2_ready_i <= 1'b1;
        @(negedge g_clk);
        check_comb(0, 1'b1);
        check_stage(n - 1);
        @(posedge g_clk);
        s1_valid_i <= 1'b0;
        @(negedge g_clk);
        check_stage(0);

        // Flush wins over a pending capture
        @(posedge g_clk);
        drive_entry(1, 1'b1);
        s1_flush_i <= 1'b1;
        @(posedge g_clk);
        s1_valid_i <= 1'b0;
        s1_flush_i <= 1'b0;
        @(negedge g_clk);
        check_zero("flush");

        // Asynchronous reset --------------------
        @(posedge g_clk);
        drive_entry(2, 1'b1);
        @(posedge g_clk);
        s1_valid_i <= 1'b0;
        @(negedge g_clk);
        check_stage(2);
        @(posedge g_clk);
        rst_n_i <= 1'b0;
        @(negedge g_clk);
        check_zero("reset");
        @(posedge g_clk);
        rst_n_i <= 1'b1;
        @(negedge g_clk);

        $display("checks run: %0d, mismatches: %0d", checks, mismatches);
        if (mismatches == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/decode_pkg.sv
rtl/uop_if.sv
rtl/uop_decode.sv
rtl/imm_gen.sv
rtl/operand_select.sv
rtl/decode_stage_reg.sv
rtl/decode_stage.sv
tb/tb_decode_stage.sv
